// File: all.f
verilog/motorPkg.sv
verilog/m3StepTimer.sv
verilog/pwmGenerator.sv
verilog/gateCommutator.sv
verilog/motorPwmTop.sv
verification/tbMotorPwm.sv

// File: run.sh
#!/bin/sh
# build and run the motor pwm testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tbMotorPwm -f all.f -o simMotorPwm
./obj_dir/simMotorPwm > sim.log 2>&1 || true
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: verification/tbMotorPwm.sv
`timescale 1ns/1ns
`default_nettype none

// directed testbench of the motor pwm core
module tbMotorPwm;

    localparam int CNT_W       = 25;
    localparam int PWM_MIN     = 256;
    localparam int DEAD_CYCLES = 4;

    logic                   clk;
    logic                   rstN;
    logic                   pwmActive;
    logic [CNT_W-1:0]       stepLen;
    motorPkg::pwmSettings_t settings;
    motorPkg::gateDrive_t   gates;
    motorPkg::pwmStatus_t   status;
    motorPkg::stepNum_t     sgStep;
    logic                   pwm;

    // lfsr state and free running cycle number
    logic [15:0] lfsr = 16'd27987;
    int          cycleCnt = 0;

    motorPwmTop #(
        .CNT_W       (CNT_W),
        .PWM_MIN     (PWM_MIN),
        .DEAD_CYCLES (DEAD_CYCLES)
    ) i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .pwmActive   (pwmActive),
        .stepLen     (stepLen),
        .settings    (settings),
        .gates       (gates),
        .status      (status),
        .sgStep      (sgStep),
        .pwm         (pwm)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic randomBits(input int nBits, output int value);
        int i;
        value = 0;
        for (i = 0; i < nBits; i++) begin
            lfsr  = lfsrNext(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkStep(input string name, input motorPkg::stepNum_t expVal,
                             input motorPkg::stepNum_t actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("FAIL %s expected %0d actual %0d", name, expVal, actVal));
        end
    endtask

    task automatic checkGates(input string name, input motorPkg::gateDrive_t expVal,
                              input motorPkg::gateDrive_t actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("FAIL %s expected %b actual %b", name, expVal, actVal));
        end
    endtask

    task automatic checkCount(input string name, input logic [15:0] expVal,
                              input logic [15:0] actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("FAIL %s expected %0d actual %0d", name, expVal, actVal));
        end
    endtask

    // sector rule, two steps per sector
    function automatic int sectorOf(input motorPkg::stepNum_t step);
        return int'(step) / 2;
    endfunction

    // gate pattern from the sector table, pwm chops the high side
    function automatic motorPkg::gateDrive_t expectedGates(input motorPkg::stepNum_t step,
                                                           input logic p);
        motorPkg::gateDrive_t g;
        g = '0;
        case (sectorOf(step))
            0: begin
                g.highA = p;
                g.lowB  = 1'b1;
            end
            1: begin
                g.highA = p;
                g.lowC  = 1'b1;
            end
            2: begin
                g.highB = p;
                g.lowC  = 1'b1;
            end
            3: begin
                g.highB = p;
                g.lowA  = 1'b1;
            end
            4: begin
                g.highC = p;
                g.lowA  = 1'b1;
            end
            default: begin
                g.highC = p;
                g.lowB  = 1'b1;
            end
        endcase
        return g;
    endfunction

    // new settings while idle, then activate
    // returns at the sample point of the first active cycle
    task automatic startRun(input int len, input motorPkg::pwmSettings_t s);
        @(posedge clk);
        pwmActive <= 1'b0;
        stepLen   <= CNT_W'(len);
        settings  <= s;
        repeat (3) @(posedge clk);
        pwmActive <= 1'b1;
        @(negedge clk);
    endtask

    task automatic waitStep(input motorPkg::stepNum_t target, input int limit);
        int waited;
        waited = 0;
        while (sgStep !== target) begin
            if (waited >= limit) begin
                stopOnError($sformatf("timeout waiting for step %0d", target));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // waits for the next high run of pwm and measures it
    task automatic measureRun(input string name, input int limit,
                              output int startAt, output int len);
        int waited;
        waited = 0;
        while (pwm !== 1'b1) begin
            if (waited >= limit) begin
                stopOnError($sformatf("%s: pwm pulse did not come in time", name));
            end
            waited++;
            @(negedge clk);
        end
        startAt = cycleCnt;
        len     = 0;
        while (pwm === 1'b1) begin
            if (len >= limit) begin
                stopOnError($sformatf("%s: pwm stuck high", name));
            end
            len++;
            @(negedge clk);
        end
    endtask

    // everything quiet after reset and while inactive
    task automatic resetAndIdle();
        int i;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            checkCount("idle pwm", 16'd0, {15'd0, pwm});
            checkGates("idle gates", '0, gates);
            checkStep("idle step", 4'd0, sgStep);
            checkCount("idle pending sum", 16'd0, status.posSumExtA);
            checkCount("idle lost position", 16'd0, status.posLost);
        end
    endtask

    // each step value lasts stepLen cycles, 0..11 then 0
    task automatic stepSequence();
        int r;
        int len;
        int run;
        int k;
        motorPkg::stepNum_t     expStep;
        motorPkg::pwmSettings_t s;
        randomBits(6, r);
        len          = 8 + (r % 57);
        s            = '0;
        s.pwmLenWant = 16'd100;
        startRun(len, s);
        expStep = 4'd0;
        for (k = 0; k <= motorPkg::STEP_COUNT; k++) begin
            run = 0;
            // run limit doubles as the timeout
            while (sgStep == expStep && run <= len) begin
                run++;
                @(negedge clk);
            end
            checkCount("step length", 16'(len), 16'(run));
            if (expStep == motorPkg::stepNum_t'(motorPkg::STEP_COUNT - 1)) begin
                expStep = 4'd0;
            end else begin
                expStep = expStep + 4'd1;
            end
            checkStep("step order", expStep, sgStep);
        end
    endtask

    // plLen at or above the minimum goes out once per period
    task automatic directPulses();
        int r;
        int w;
        int l;
        int k;
        int startAt;
        int len;
        int prevStart;
        motorPkg::pwmSettings_t s;
        randomBits(7, r);
        w = 400 + r;
        randomBits(8, r);
        l = PWM_MIN + (r % (w - PWM_MIN));
        s            = '0;
        s.pwmLenWant = 16'(w);
        s.plLen      = 16'(l);
        s.posLimitB  = 16'hFFFF;
        s.posLimitC  = 16'hFFFF;
        // one long step 0 holds all measured periods
        startRun(6 * w + 50, s);
        prevStart = 0;
        for (k = 0; k < 4; k++) begin
            measureRun("direct pulse", 2 * w, startAt, len);
            checkCount("direct pulse length", 16'(l), 16'(len));
            if (k > 0) begin
                checkCount("direct pulse period", 16'(w), 16'(startAt - prevStart));
            end
            prevStart = startAt;
        end
    endtask

    // short lengths add up to the first sum that reaches the minimum
    task automatic heldBackPulses();
        int r;
        int w;
        int l;
        int k;
        int expLen;
        int periods;
        int startAt;
        int len;
        motorPkg::pwmSettings_t s;
        randomBits(8, r);
        l = 40 + (r % 200);
        randomBits(6, r);
        w      = 300 + r;
        expLen = 0;
        while (expLen < PWM_MIN) begin
            expLen = expLen + l;
        end
        periods      = expLen / l;
        s            = '0;
        s.pwmLenWant = 16'(w);
        s.plLen      = 16'(l);
        s.posLimitB  = 16'hFFFF;
        s.posLimitC  = 16'hFFFF;
        startRun(4 * periods * w, s);
        // pending sum is plLen alone at the start
        checkCount("pending sum at start", 16'(l), status.posSumExtA);
        // one period later the first length is held back
        repeat (w) @(negedge clk);
        checkCount("pending sum after one period", 16'(2 * l), status.posSumExtA);
        for (k = 0; k < 3; k++) begin
            measureRun("held back pulse", periods * w + w, startAt, len);
            checkCount("held back pulse length", 16'(expLen), 16'(len));
        end
    endtask

    // counts pwm high cycles of one step, skipping a pulse left from the step before
    task automatic highCyclesInStep(input motorPkg::stepNum_t target, input int len,
                                    input int skip, output int highs);
        int i;
        waitStep(target, 8 * len);
        highs = 0;
        for (i = 1; i <= len; i++) begin
            if (i > skip && pwm === 1'b1) begin
                highs++;
            end
            @(negedge clk);
        end
    endtask

    // limits below plLen block every load in steps 6 and 11
    task automatic limitSteps();
        int r;
        int w;
        int l;
        int len;
        int highs;
        motorPkg::pwmSettings_t s;
        randomBits(6, r);
        w = 300 + r;
        randomBits(5, r);
        l            = PWM_MIN + r;
        s            = '0;
        s.pwmLenWant = 16'(w);
        s.plLen      = 16'(l);
        randomBits(6, r);
        s.posLimitB = 16'(l - 1 - r);
        randomBits(6, r);
        s.posLimitC = 16'(l - 1 - r);
        len         = 3 * w + 17;
        startRun(len, s);
        highCyclesInStep(motorPkg::STEP_LIMIT_B, len, l + 1, highs);
        checkCount("limit step 6 pwm high cycles", 16'd0, 16'(highs));
        highCyclesInStep(motorPkg::STEP_LIMIT_C, len, l + 1, highs);
        checkCount("limit step 11 pwm high cycles", 16'd0, 16'(highs));
    endtask

    // full turn with a cycle by cycle gate model
    task automatic commutation();
        int r;
        int w;
        int len;
        int i;
        int deadLeft;
        int changes;
        int highSeen;
        logic                   prevPwm;
        motorPkg::stepNum_t     prevStep;
        motorPkg::stepNum_t     prevPrevStep;
        motorPkg::gateDrive_t   expGates;
        motorPkg::pwmSettings_t s;
        w = 300;
        randomBits(5, r);
        s            = '0;
        s.pwmLenWant = 16'(w);
        s.plLen      = 16'(PWM_MIN + r);
        s.posLimitB  = 16'hFFFF;
        s.posLimitC  = 16'hFFFF;
        randomBits(6, r);
        len = 2 * w + r;
        startRun(len, s);
        // gates follow the previous cycle's pwm and step
        prevStep     = sgStep;
        prevPrevStep = sgStep;
        prevPwm      = pwm;
        deadLeft     = 0;
        changes      = 0;
        highSeen     = 0;
        for (i = 0; i < motorPkg::STEP_COUNT * len + 8; i++) begin
            @(negedge clk);
            if (sectorOf(prevStep) != sectorOf(prevPrevStep)) begin
                deadLeft = DEAD_CYCLES;
                changes++;
            end
            if (deadLeft > 0) begin
                expGates = '0;
                deadLeft--;
            end else begin
                expGates = expectedGates(prevStep, prevPwm);
            end
            if ((gates.highA && gates.lowA) || (gates.highB && gates.lowB) ||
                (gates.highC && gates.lowC)) begin
                stopOnError("both gates of one phase are on at once");
            end
            checkGates("commutation gates", expGates, gates);
            if (gates.highA || gates.highB || gates.highC) begin
                highSeen++;
            end
            prevPrevStep = prevStep;
            prevStep     = sgStep;
            prevPwm      = pwm;
        end
        checkCount("sector changes per turn", 16'd6, 16'(changes));
        if (highSeen == 0) begin
            stopOnError("no high side gate switched during a full turn");
        end
    endtask

    // lost position per step with pulses that fit inside their step
    task automatic lostPosition();
        int r;
        int w;
        int l;
        int k;
        int expLost;
        motorPkg::pwmSettings_t s;
        randomBits(6, r);
        w = 300 + r;
        randomBits(5, r);
        l            = PWM_MIN + r;
        s            = '0;
        s.pwmLenWant = 16'(w);
        s.plLen      = 16'(l);
        s.posLimitB  = 16'hFFFF;
        s.posLimitC  = 16'hFFFF;
        // two whole periods per step
        startRun(2 * w, s);
        expLost = 0;
        for (k = 1; k < motorPkg::STEP_COUNT; k++) begin
            // only step 0 misses the pulse carried over from the step before it
            // steps 1 and 7 restart the sum
            if (k == 1) begin
                expLost = l;
            end else if (k == 7) begin
                expLost = 0;
            end
            waitStep(motorPkg::stepNum_t'(k), 4 * w);
            // booked on the first cycle of the step
            @(negedge clk);
            checkCount("lost position", 16'(expLost), status.posLost);
            checkCount("pending sum in step", 16'(l), status.posSumExtA);
        end
    endtask

    initial begin
        rstN      <= 1'b0;
        pwmActive <= 1'b0;
        stepLen   <= CNT_W'(8);
        settings  <= '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        resetAndIdle();
        stepSequence();
        directPulses();
        heldBackPulses();
        limitSteps();
        commutation();
        lostPosition();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/gateCommutator.sv
`timescale 1ns/1ns
`default_nettype none

// six step gate commutator
// pwm chops the high side, one low side is held on per sector
module gateCommutator #(
    parameter int DEAD_CYCLES = 4
) (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     pwmActive,
    input  wire                     pwm,
    input  wire motorPkg::stepNum_t sgStep,
    output motorPkg::gateDrive_t    gates
);

    localparam int DEAD_W = $clog2(DEAD_CYCLES + 1);

    // phase codes, NONE for unused sectors
    localparam logic [1:0] PH_A    = 2'd0;
    localparam logic [1:0] PH_B    = 2'd1;
    localparam logic [1:0] PH_C    = 2'd2;
    localparam logic [1:0] PH_NONE = 2'd3;

    // two steps per sector
    logic [2:0]              sector;
    logic [2:0]              sectorQ;
    logic                    sectorChange;

    logic [1:0]              highPhase;
    logic [1:0]              lowPhase;

    // dead time counter and blanking
    logic [DEAD_W-1:0]       deadCnt;
    logic                    blank;

    motorPkg::gateDrive_t    gatesNext;

    assign sector = sgStep[3:1];

    // sector table
    always_comb begin
        case (sector)
            3'd0: begin
                highPhase = PH_A;
                lowPhase  = PH_B;
            end
            3'd1: begin
                highPhase = PH_A;
                lowPhase  = PH_C;
            end
            3'd2: begin
                highPhase = PH_B;
                lowPhase  = PH_C;
            end
            3'd3: begin
                highPhase = PH_B;
                lowPhase  = PH_A;
            end
            3'd4: begin
                highPhase = PH_C;
                lowPhase  = PH_A;
            end
            3'd5: begin
                highPhase = PH_C;
                lowPhase  = PH_B;
            end
            default: begin
                // steps 12..15 never occur, keep every switch open
                highPhase = PH_NONE;
                lowPhase  = PH_NONE;
            end
        endcase
    end

    assign sectorChange = pwmActive && (sector != sectorQ);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sectorQ <= '0;
        end else begin
            sectorQ <= sector;
        end
    end

    // change cycle plus DEAD_CYCLES-1 counted cycles give DEAD_CYCLES blank outputs
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            deadCnt <= '0;
        end else if (sectorChange) begin
            deadCnt <= DEAD_W'(DEAD_CYCLES - 1);
        end else if (deadCnt != '0) begin
            deadCnt <= deadCnt - DEAD_W'(1);
        end
    end

    assign blank = sectorChange || (deadCnt != '0);

    always_comb begin
        gatesNext       = '0;
        gatesNext.highA = pwm && (highPhase == PH_A);
        gatesNext.highB = pwm && (highPhase == PH_B);
        gatesNext.highC = pwm && (highPhase == PH_C);
        gatesNext.lowA  = (lowPhase == PH_A);
        gatesNext.lowB  = (lowPhase == PH_B);
        gatesNext.lowC  = (lowPhase == PH_C);
    end

    // gate register, one cycle behind pwm and sgStep
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gates <= '0;
        end else if (!pwmActive || blank) begin
            gates <= '0;
        end else begin
            gates <= gatesNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/m3StepTimer.sv
`timescale 1ns/1ns
`default_nettype none

// commutation step timer
// each step lasts stepLen cycles, the step number wraps after the last step
module m3StepTimer #(
    parameter int CNT_W = 25
) (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire                       pwmActive,
    input  wire [CNT_W-1:0]           stepLen,
    output motorPkg::m3Strobes_t      strobes,
    output motorPkg::stepNum_t        sgStep
);

    // step down counter, stepLen-1 .. 0
    logic [CNT_W-1:0] m3cnt;

    // reload value and the value one cycle after it
    logic [CNT_W-1:0] lenM1;
    logic [CNT_W-1:0] lenM2;

    // last cycle of the running step
    logic             stepEnd;

    // last step of the turn
    logic             lastStep;

    assign lenM1    = stepLen - CNT_W'(1);
    assign lenM2    = stepLen - CNT_W'(2);

    // strobes only count while the core runs
    assign stepEnd  = pwmActive && (m3cnt == '0);

    assign lastStep = (sgStep == motorPkg::stepNum_t'(motorPkg::STEP_COUNT - 1));

    // counter parks on the reload value while inactive,
    // so the first active cycle is already the first cycle of step 0
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            m3cnt <= '0;
        end else if (!pwmActive) begin
            m3cnt <= lenM1;
        end else if (m3cnt == '0) begin
            m3cnt <= lenM1;
        end else begin
            m3cnt <= m3cnt - CNT_W'(1);
        end
    end

    // step number moves on right after last1
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sgStep <= '0;
        end else if (!pwmActive) begin
            sgStep <= '0;
        end else if (stepEnd) begin
            if (lastStep) begin
                // wrap 11 -> 0
                sgStep <= '0;
            end else begin
                sgStep <= sgStep + 4'd1;
            end
        end
    end

    // strobe decode from the counter value
    // stepLen is at least 8 so the four positions never overlap
    always_comb begin
        strobes        = '0;
        strobes.first1 = pwmActive && (m3cnt == lenM1);
        strobes.first2 = pwmActive && (m3cnt == lenM2);
        strobes.last2  = pwmActive && (m3cnt == CNT_W'(1));
        strobes.last1  = stepEnd;
    end

endmodule

`default_nettype wire

// File: verilog/motorPkg.sv
`default_nettype none

// shared types and step constants of the motor pwm core
package motorPkg;

    // step number within one electrical turn
    typedef logic [3:0] stepNum_t;

    // commutation steps per electrical turn
    localparam int STEP_COUNT = 12;

    // steps in which the pending sum is checked against a limit
    localparam stepNum_t STEP_LIMIT_B = 4'd6;
    localparam stepNum_t STEP_LIMIT_C = 4'd11;

    // steps in which the lost position sum restarts
    localparam stepNum_t STEP_LOST_CLEAR_A = 4'd1;
    localparam stepNum_t STEP_LOST_CLEAR_B = 4'd7;

    // one-cycle markers at both ends of a step
    typedef struct packed {
        // first cycle of a step
        logic first1;
        // second cycle of a step
        logic first2;
        // second to last cycle
        logic last2;
        // last cycle, the step number moves on after it
        logic last1;
    } m3Strobes_t;

    // settings, stable while the core is active
    typedef struct packed {
        // pwm period in clock cycles
        logic [15:0] pwmLenWant;
        // position length wanted per period
        logic [15:0] plLen;
        // pending sum limit in step 6
        logic [15:0] posLimitB;
        // pending sum limit in step 11
        logic [15:0] posLimitC;
    } pwmSettings_t;

    // status seen from outside
    typedef struct packed {
        logic [15:0] posSumExtA;
        logic [15:0] posLost;
    } pwmStatus_t;

    // six gate lines of the three half bridges
    typedef struct packed {
        logic highA;
        logic lowA;
        logic highB;
        logic lowB;
        logic highC;
        logic lowC;
    } gateDrive_t;

endpackage

`default_nettype wire

// File: verilog/motorPwmTop.sv
`timescale 1ns/1ns
`default_nettype none

// pwm core of the three phase bldc controller
// timer -> generator -> commutator, the timer step also feeds the commutator
module motorPwmTop #(
    // step counter width
    parameter int CNT_W       = 25,
    // shortest pulse the drivers can follow
    parameter int PWM_MIN     = 256,
    // gate blanking after a sector change
    parameter int DEAD_CYCLES = 4
) (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire                         pwmActive,
    input  wire [CNT_W-1:0]             stepLen,
    input  wire motorPkg::pwmSettings_t settings,
    output motorPkg::gateDrive_t        gates,
    output motorPkg::pwmStatus_t        status,
    output motorPkg::stepNum_t          sgStep,
    output logic                        pwm
);

    // step boundary markers from the timer
    motorPkg::m3Strobes_t strobes;

    m3StepTimer #(
        .CNT_W       (CNT_W)
    ) i_stepTimer (
        .clk         (clk),
        .rstN        (rstN),
        .pwmActive   (pwmActive),
        .stepLen     (stepLen),
        .strobes     (strobes),
        .sgStep      (sgStep)
    );

    // position pulses, limits checked against the current step
    pwmGenerator #(
        .PWM_MIN     (PWM_MIN)
    ) i_pwmGenerator (
        .clk         (clk),
        .rstN        (rstN),
        .pwmActive   (pwmActive),
        .strobes     (strobes),
        .sgStep      (sgStep),
        .settings    (settings),
        .pwm         (pwm),
        .status      (status)
    );

    // pwm and step combined into six gate lines
    gateCommutator #(
        .DEAD_CYCLES (DEAD_CYCLES)
    ) i_gateCommutator (
        .clk         (clk),
        .rstN        (rstN),
        .pwmActive   (pwmActive),
        .pwm         (pwm),
        .sgStep      (sgStep),
        .gates       (gates)
    );

endmodule

`default_nettype wire

// File: verilog/pwmGenerator.sv
`timescale 1ns/1ns
`default_nettype none

// position pulse pwm generator
// turns a wanted position length per period into mosfet on time
// short lengths are held back and summed until they reach PWM_MIN
module pwmGenerator #(
    parameter int PWM_MIN = 256
) (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire                       pwmActive,
    input  wire motorPkg::m3Strobes_t strobes,
    input  wire motorPkg::stepNum_t   sgStep,
    input  wire motorPkg::pwmSettings_t settings,
    output logic                      pwm,
    output motorPkg::pwmStatus_t      status
);

    // minimum pulse at the width of the position words
    localparam logic [15:0] PWM_MIN_W = 16'(PWM_MIN);

    // pwm period down counter
    logic [15:0] pwmCnt;
    logic        periodEnd;

    // held back position and pending sum
    logic [15:0] posRemain;
    logic [15:0] posSum;
    logic        posLoad;

    // on time still to emit in the current pulse
    logic [15:0] pulseCnt;

    // wanted and delivered on time of the running step
    logic [15:0] posWant;
    logic [15:0] posReal;

    // copies taken at last2, used at the next first1
    logic [15:0] posWantCopy;
    logic [15:0] posRealCopy;

    // shortfall of the last step and running sum
    logic [15:0] posDiff;
    logic [15:0] posLost;

    // reading 1 closes the period
    assign periodEnd = pwmActive && (pwmCnt == 16'd1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pwmCnt <= '0;
        end else if (!pwmActive) begin
            pwmCnt <= settings.pwmLenWant;
        end else if (strobes.last1) begin
            // periods restart at every step boundary
            pwmCnt <= settings.pwmLenWant;
        end else if (pwmCnt == 16'd1) begin
            pwmCnt <= settings.pwmLenWant;
        end else begin
            pwmCnt <= pwmCnt - 16'd1;
        end
    end

    // remainder plus this period's wanted length
    assign posSum = posRemain + settings.plLen;

    // load decision
    // steps 6 and 11 also cap the pending sum
    always_comb begin
        posLoad = (posSum >= PWM_MIN_W);
        if (sgStep == motorPkg::STEP_LIMIT_B) begin
            posLoad = posLoad && (posSum <= settings.posLimitB);
        end else if (sgStep == motorPkg::STEP_LIMIT_C) begin
            posLoad = posLoad && (posSum <= settings.posLimitC);
        end
    end

    // remainder keeps what could not be emitted yet
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            posRemain <= '0;
        end else if (!pwmActive) begin
            posRemain <= '0;
        end else if (strobes.last2) begin
            // nothing is carried across a step end
            posRemain <= '0;
        end else if (periodEnd) begin
            if (posLoad) begin
                posRemain <= '0;
            end else begin
                posRemain <= posSum;
            end
        end
    end

    // pulse counter, pwm is high while it is nonzero
    // loaded with L at the period end gives L high cycles after it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pulseCnt <= '0;
        end else if (!pwmActive) begin
            pulseCnt <= '0;
        end else if (periodEnd && posLoad) begin
            pulseCnt <= posSum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 16'd1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // wanted on time, plLen per closed period
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            posWant <= '0;
        end else if (!pwmActive) begin
            posWant <= '0;
        end else if (strobes.first2) begin
            posWant <= settings.plLen;
        end else if (periodEnd) begin
            posWant <= posWant + settings.plLen;
        end
    end

    // delivered on time, one count per high cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            posReal <= '0;
        end else if (!pwmActive || strobes.last2) begin
            posReal <= '0;
        end else if (pwm) begin
            posReal <= posReal + 16'd1;
        end
    end

    // freeze both figures at the end of the step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            posWantCopy <= '0;
            posRealCopy <= '0;
        end else if (strobes.last2) begin
            posWantCopy <= posWant;
            posRealCopy <= posReal;
        end
    end

    assign posDiff = posWantCopy - posRealCopy;

    // lost position, booked at the first cycle of the next step
    // steps 1 and 7 start a new half turn sum
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            posLost <= '0;
        end else if (strobes.first1) begin
            if (sgStep == motorPkg::STEP_LOST_CLEAR_A ||
                sgStep == motorPkg::STEP_LOST_CLEAR_B) begin
                posLost <= posDiff;
            end else begin
                posLost <= posLost + posDiff;
            end
        end
    end

    always_comb begin
        status            = '0;
        status.posSumExtA = posSum;
        status.posLost    = posLost;
    end

endmodule

`default_nettype wire
